/* Makefile */
TOP = tb_muldiv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): muldiv.f *.sv *.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f muldiv.f

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert --top-module muldiv_unit -f muldiv.f

clean:
	rm -rf obj_dir sim.log

/* div_core.sv */
/* unsigned radix-2 restoring divider
   one quotient bit per cycle, quotient and remainder out */
`timescale 1ns/1ps
`default_nettype none

module div_core
    import muldiv_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  start_i,
    input  xlen_t op_a_i,
    input  xlen_t op_b_i,
    output logic  done_o,
    output xlen_t quot_o,
    output xlen_t rem_o
);

    logic [ST_W-1:0]   state_q;
    logic [STEP_W-1:0] step_q;
    xlen_t             quot_q;
    xlen_t             rem_q;
    xlen_t             divisor_q;
    logic [XLEN+1:0]   trial;
    logic              trial_neg;

    // shift in next dividend bit and try the subtraction
    assign trial     = {1'b0, rem_q, quot_q[XLEN-1]} - {2'b00, divisor_q};
    assign trial_neg = trial[XLEN+1];

    assign quot_o = quot_q;
    assign rem_o  = rem_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (1'b1)
                state_q[ST_IDLE_BIT]: begin
                    if (start_i) begin
                        state_q <= ST_LOAD;
                    end
                end
                state_q[ST_LOAD_BIT]: begin
                    step_q  <= '0;
                    state_q <= ST_CALC;
                end
                state_q[ST_CALC_BIT]: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_LAST) begin
                        done_o  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // dividend shifts out of quot_q while quotient bits shift in
    always_ff @(posedge clk) begin
        if (state_q[ST_LOAD_BIT]) begin
            quot_q    <= op_a_i;
            rem_q     <= '0;
            divisor_q <= op_b_i;
        end else if (state_q[ST_CALC_BIT]) begin
            quot_q <= {quot_q[XLEN-2:0], ~trial_neg};
            if (trial_neg) begin
                // restore
                rem_q <= {rem_q[XLEN-2:0], quot_q[XLEN-1]};
            end else begin
                rem_q <= trial[XLEN-1:0];
            end
        end
    end

    // controller only starts an idle core
    assert property (@(posedge clk) disable iff (!resetn)
        start_i |-> state_q[ST_IDLE_BIT])
        else $error("div_core: start while not idle");

endmodule

`default_nettype wire

/* mul_core.sv */
/* unsigned 32x32 shift-and-add multiplier
   one multiplier bit per cycle, 64-bit product */
`timescale 1ns/1ps
`default_nettype none

module mul_core
    import muldiv_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   start_i,
    input  xlen_t  op_a_i,
    input  xlen_t  op_b_i,
    output logic   done_o,
    output dxlen_t product_o
);

    logic [ST_W-1:0]   state_q;
    logic [STEP_W-1:0] step_q;
    dxlen_t            acc_q;
    dxlen_t            mcand_q;
    xlen_t             mplier_q;
    dxlen_t            addend;

    assign addend    = mplier_q[0] ? mcand_q : '0;
    assign product_o = acc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (1'b1)
                state_q[ST_IDLE_BIT]: begin
                    if (start_i) begin
                        state_q <= ST_LOAD;
                    end
                end
                state_q[ST_LOAD_BIT]: begin
                    step_q  <= '0;
                    state_q <= ST_CALC;
                end
                state_q[ST_CALC_BIT]: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_LAST) begin
                        done_o  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // datapath, operands stay stable at the ports until done
    always_ff @(posedge clk) begin
        if (state_q[ST_LOAD_BIT]) begin
            acc_q    <= '0;
            mcand_q  <= {{XLEN{1'b0}}, op_a_i};
            mplier_q <= op_b_i;
        end else if (state_q[ST_CALC_BIT]) begin
            acc_q    <= acc_q + addend;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // controller only starts an idle core
    assert property (@(posedge clk) disable iff (!resetn)
        start_i |-> state_q[ST_IDLE_BIT])
        else $error("mul_core: start while not idle");

endmodule

`default_nettype wire

/* muldiv.f */
+incdir+.
muldiv_pkg.sv
mul_core.sv
div_core.sv
muldiv_ctrl.sv
muldiv_unit.sv
tb_muldiv.sv

/* muldiv_ctrl.sv */
/* rv32m command controller
   decodes funct3, feeds absolute operands to a core, sign-corrects the result */
`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl
    import muldiv_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       cmd_valid_i,
    input  muldiv_op_t cmd_op_i,
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    output logic       result_valid_o,
    output xlen_t      result_o,
    output logic       busy_o,
    output logic       mul_start_o,
    output logic       div_start_o,
    output xlen_t      op_a_o,
    output xlen_t      op_b_o,
    input  logic       mul_done_i,
    input  dxlen_t     product_i,
    input  logic       div_done_i,
    input  xlen_t      quot_i,
    input  xlen_t      rem_i
);

    logic       cmd_is_mul;
    logic       cmd_a_signed;
    logic       cmd_b_signed;
    logic       cmd_a_neg;
    logic       cmd_b_neg;

    muldiv_op_t op_q;
    logic       a_neg_q;
    logic       b_neg_q;
    logic       b_zero_q;

    logic       core_done;
    logic       signs_differ;
    dxlen_t     product_fix;
    xlen_t      quot_fix;
    xlen_t      rem_fix;
    xlen_t      result_next;

    // which core, which operands are signed
    always_comb begin
        cmd_is_mul   = 1'b0;
        cmd_a_signed = 1'b0;
        cmd_b_signed = 1'b0;
        case (cmd_op_i)
            OP_MUL, OP_MULHU: begin
                cmd_is_mul = 1'b1;
            end
            OP_MULH: begin
                cmd_is_mul   = 1'b1;
                cmd_a_signed = 1'b1;
                cmd_b_signed = 1'b1;
            end
            OP_MULHSU: begin
                cmd_is_mul   = 1'b1;
                cmd_a_signed = 1'b1;
            end
            OP_DIV, OP_REM: begin
                cmd_a_signed = 1'b1;
                cmd_b_signed = 1'b1;
            end
            default: begin
                cmd_is_mul = 1'b0;
            end
        endcase
    end

    assign cmd_a_neg = cmd_a_signed & rs1_i[XLEN-1];
    assign cmd_b_neg = cmd_b_signed & rs2_i[XLEN-1];

    assign core_done    = mul_done_i | div_done_i;
    assign signs_differ = a_neg_q ^ b_neg_q;

    // negate the full product so the upper half is right
    assign product_fix = signs_differ ? -product_i : product_i;
    // divide by zero keeps the all-ones quotient
    assign quot_fix    = (signs_differ && !b_zero_q) ? -quot_i : quot_i;
    // remainder follows the dividend sign
    assign rem_fix     = a_neg_q ? -rem_i : rem_i;

    always_comb begin
        case (op_q)
            OP_MUL: begin
                result_next = product_fix[XLEN-1:0];
            end
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                result_next = product_fix[2*XLEN-1:XLEN];
            end
            OP_DIV, OP_DIVU: begin
                result_next = quot_fix;
            end
            default: begin
                result_next = rem_fix;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_o         <= 1'b0;
            result_valid_o <= 1'b0;
            mul_start_o    <= 1'b0;
            div_start_o    <= 1'b0;
        end else begin
            result_valid_o <= core_done;
            mul_start_o    <= cmd_valid_i & cmd_is_mul;
            div_start_o    <= cmd_valid_i & ~cmd_is_mul;
            if (core_done) begin
                busy_o <= 1'b0;
            end
            if (cmd_valid_i) begin
                busy_o <= 1'b1;
            end
        end
    end

    // command capture, operands held until the core is done
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            op_q     <= cmd_op_i;
            a_neg_q  <= cmd_a_neg;
            b_neg_q  <= cmd_b_neg;
            b_zero_q <= (rs2_i == '0);
            op_a_o   <= cmd_a_neg ? -rs1_i : rs1_i;
            op_b_o   <= cmd_b_neg ? -rs2_i : rs2_i;
        end
        if (core_done) begin
            result_o <= result_next;
        end
    end

    // one operation in flight, source waits for busy low
    assert property (@(posedge clk) disable iff (!resetn)
        cmd_valid_i |-> !busy_o)
        else $error("muldiv_ctrl: command issued while busy");

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
/* rv32m multiply/divide shared types and constants
   word types, funct3 operation codes and iteration settings */
`default_nettype none

package muldiv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [2*XLEN-1:0] dxlen_t;

    // values match the rv32m funct3 field
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_t;

    // one bit per operand bit
    localparam int STEP_W = 5;
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(XLEN - 1);

    // one-hot core states
    localparam int ST_W        = 3;
    localparam int ST_IDLE_BIT = 0;
    localparam int ST_LOAD_BIT = 1;
    localparam int ST_CALC_BIT = 2;

    localparam logic [ST_W-1:0] ST_IDLE = ST_W'(1) << ST_IDLE_BIT;
    localparam logic [ST_W-1:0] ST_LOAD = ST_W'(1) << ST_LOAD_BIT;
    localparam logic [ST_W-1:0] ST_CALC = ST_W'(1) << ST_CALC_BIT;

endpackage

`default_nettype wire

/* muldiv_unit.sv */
/* rv32m multiply/divide unit top
   controller plus shift-and-add multiplier and restoring divider */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
    import muldiv_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       cmd_valid_i,
    input  muldiv_op_t cmd_op_i,
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    output logic       result_valid_o,
    output xlen_t      result_o,
    output logic       busy_o
);

    logic   mul_start;
    logic   div_start;
    xlen_t  op_a;
    xlen_t  op_b;
    logic   mul_done;
    dxlen_t product;
    logic   div_done;
    xlen_t  quot;
    xlen_t  rem;

    muldiv_ctrl muldiv_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_op_i       (cmd_op_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .busy_o         (busy_o),
        .mul_start_o    (mul_start),
        .div_start_o    (div_start),
        .op_a_o         (op_a),
        .op_b_o         (op_b),
        .mul_done_i     (mul_done),
        .product_i      (product),
        .div_done_i     (div_done),
        .quot_i         (quot),
        .rem_i          (rem)
    );

    mul_core mul_core_i (
        .clk       (clk),
        .resetn    (resetn),
        .start_i   (mul_start),
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .done_o    (mul_done),
        .product_o (product)
    );

    div_core div_core_i (
        .clk     (clk),
        .resetn  (resetn),
        .start_i (div_start),
        .op_a_i  (op_a),
        .op_b_i  (op_b),
        .done_o  (div_done),
        .quot_o  (quot),
        .rem_o   (rem)
    );

endmodule

`default_nettype wire

/* tb_muldiv_model.svh */
/* reference model for the rv32m multiply/divide unit testbench
   expected results per funct3 operation and an xorshift generator */
`ifndef TB_MULDIV_MODEL_SVH
`define TB_MULDIV_MODEL_SVH

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic xlen_t model_result(input muldiv_op_t op, input xlen_t a, input xlen_t b);
    longint      sa;
    longint      sb;
    longint      ub;
    logic [63:0] wide;
    logic        overflow;
    xlen_t       res;
    sa       = {{32{a[31]}}, a};
    sb       = {{32{b[31]}}, b};
    ub       = {32'h0, b};
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    wide     = '0;
    res      = '0;
    case (op)
        OP_MUL: begin
            wide = sa * sb;
            res  = wide[31:0];
        end
        OP_MULH: begin
            wide = sa * sb;
            res  = wide[63:32];
        end
        OP_MULHSU: begin
            wide = sa * ub;
            res  = wide[63:32];
        end
        OP_MULHU: begin
            wide = {32'h0, a} * {32'h0, b};
            res  = wide[63:32];
        end
        OP_DIV: begin
            if (b == '0) begin
                res = '1;
            end else if (overflow) begin
                res = a;
            end else begin
                // truncates toward zero
                wide = sa / sb;
                res  = wide[31:0];
            end
        end
        OP_DIVU: begin
            res = (b == '0) ? '1 : a / b;
        end
        OP_REM: begin
            if (b == '0) begin
                res = a;
            end else if (overflow) begin
                res = '0;
            end else begin
                // sign follows the dividend
                wide = sa % sb;
                res  = wide[31:0];
            end
        end
        default: begin
            res = (b == '0) ? a : a % b;
        end
    endcase
    return res;
endfunction

`endif

/* tb_muldiv.sv */
/* testbench for the rv32m multiply/divide unit
   random and corner commands checked for value and latency */
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam logic [31:0] SEED       = 32'd18226;
    localparam int          LATENCY    = 35;
    localparam int          WAIT_LIMIT = 100;
    localparam int          NUM_RANDOM = 300;

    logic       clk;
    logic       resetn;
    logic       cmd_valid;
    muldiv_op_t cmd_op;
    xlen_t      rs1;
    xlen_t      rs2;
    logic       result_valid;
    xlen_t      result;
    logic       busy;

    logic [31:0] rng_state;

    `include "tb_muldiv_model.svh"

    muldiv_unit muldiv_unit_i (
        .clk            (clk),
        .resetn         (resetn),
        .cmd_valid_i    (cmd_valid),
        .cmd_op_i       (cmd_op),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .result_valid_o (result_valid),
        .result_o       (result),
        .busy_o         (busy)
    );

    always #5 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        report_error($sformatf("Fail %s: expected %08h, actual %08h", name, exp, act));
    endtask

    function automatic logic [31:0] next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // roughly a quarter of operands are corner values
    function automatic xlen_t pick_operand();
        logic [31:0] r;
        r = next_word();
        if (r[1:0] != 2'b00) begin
            return next_word();
        end
        case (r[3:2])
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'h0000_0001;
            2'd2:    return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            assert (!result_valid && !busy)
                else report_error("result_valid_o or busy_o high while idle");
        end
    endtask

    // returns one step after the result edge, so the next command lands back to back
    task automatic run_cmd(input muldiv_op_t op, input xlen_t a, input xlen_t b);
        xlen_t expected;
        string name;
        int    cycles;
        expected  = model_result(op, a, b);
        name      = $sformatf("%s %08h %08h", op.name(), a, b);
        cmd_valid = 1'b1;
        cmd_op    = op;
        rs1       = a;
        rs2       = b;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cycles    = 0;
        while (!result_valid && cycles < WAIT_LIMIT) begin
            assert (busy) else report_error({name, ": busy_o low before the result"});
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (result_valid) else report_error({name, ": timeout waiting for result_valid_o"});
        assert (cycles == LATENCY) else report_value({name, " latency"}, LATENCY, cycles);
        assert (!busy) else report_error({name, ": busy_o still high with the result"});
        assert (result == expected) else report_value(name, expected, result);
    endtask

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        resetn    = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_MUL;
        rs1       = '0;
        rs2       = '0;
        rng_state = SEED;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        idle_cycles(4);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = next_word();
            run_cmd(muldiv_op_t'(r[2:0]), pick_operand(), pick_operand());
            // mostly back to back, sometimes a short gap
            if (r[5:4] == 2'b11) begin
                idle_cycles(1 + int'(r[6]));
            end
        end

        // divide by zero and signed overflow
        run_cmd(OP_DIV, next_word(), 32'h0);
        run_cmd(OP_DIVU, next_word(), 32'h0);
        run_cmd(OP_REM, next_word(), 32'h0);
        run_cmd(OP_REMU, next_word(), 32'h0);
        run_cmd(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_cmd(OP_REM, 32'h8000_0000, 32'hffff_ffff);
        run_cmd(OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        run_cmd(OP_REMU, 32'h8000_0000, 32'hffff_ffff);
        idle_cycles(2);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
